//--- src/octree_config.svh
`ifndef OCTREE_CONFIG_SVH
`define OCTREE_CONFIG_SVH

// tree shape
`define TREE_LEVELS   5
`define LOG_CHILDREN  3

// sram geometry
`define DATA_W        64
`define ADDR_W        13
// eight children with a child bit and a self bit each
`define LANE_W        16

// feature storage
`define FEATURE_BEATS 9
`define FEATURE_BASE  4096
`define HASH_W        11

// per-level hash multipliers
`define PRIME_0       1
`define PRIME_1       2654435
`define PRIME_2       807545
`define PRIME_3       3867465
`define PRIME_4       2099719

`endif

//--- src/octree_pkg.sv
`include "octree_config.svh"

package octree_pkg;

  // level in the top bits, then offsets 0..4 from high to low
  typedef logic [`LOG_CHILDREN*(`TREE_LEVELS+1)-1:0] pos_t;

  typedef logic [2:0]                 level_t;
  typedef logic [`LOG_CHILDREN-1:0]   offset_t;
  typedef logic [`ADDR_W-1:0]         word_addr_t;
  typedef logic [`DATA_W-1:0]         data_t;
  // four sibling groups share one sram word
  typedef logic [1:0]                 lane_t;
  typedef logic [3:0]                 beat_idx_t;

  typedef enum logic {
    OP_ADD,
    OP_DEL
  } op_e;

  // used by both engines but the deleter skips W_FEATURE
  typedef enum logic [2:0] {
    W_IDLE,
    W_READ,
    W_WRITE,
    W_FEATURE,
    W_DONE
  } walk_e;

endpackage

//--- src/node_addr_calc.sv
`timescale 1ns/10ps
`include "octree_config.svh"

module node_addr_calc import octree_pkg::*; (
  input  pos_t       pos,
  input  level_t     level,
  output word_addr_t word_addr,
  output lane_t      lane,
  output offset_t    offset
);

  // two extra bits for the lane below the word address
  localparam int GW = `ADDR_W + 2;

  logic [GW-1:0] group_idx;
  offset_t       offs [`TREE_LEVELS];

  always_comb begin
    for (int i = 0; i < `TREE_LEVELS; i++) begin
      offs[i] = pos[`LOG_CHILDREN*(`TREE_LEVELS-1-i) +: `LOG_CHILDREN];
    end
  end

  // g = 8*g + off + 1 per ancestor, which folds in the level base 0, 1, 9, 73, 585
  always_comb begin
    group_idx = '0;
    for (int i = 0; i < `TREE_LEVELS; i++) begin
      if (i < int'(level)) begin
        group_idx = (group_idx << `LOG_CHILDREN) + GW'(offs[i]) + GW'(1);
      end
    end
  end

  assign word_addr = group_idx[GW-1:2];
  assign lane      = group_idx[1:0];

  // levels past the tree depth carry no offset
  assign offset = (int'(level) < `TREE_LEVELS) ? offs[level] : '0;

endmodule

//--- src/feature_buffer.sv
`timescale 1ns/10ps
`include "octree_config.svh"

module feature_buffer import octree_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      arm,
  input  logic      feat_valid,
  output logic      feat_ready,
  input  data_t     feat_data,
  input  beat_idx_t rd_idx,
  output data_t     rd_data,
  output logic      full,
  input  logic      clear
);

  data_t     beats [`FEATURE_BEATS];
  beat_idx_t wr_cnt;
  logic      take;

  assign take = feat_valid && feat_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_ready <= 1'b0;
      full       <= 1'b0;
      wr_cnt     <= '0;
    end else begin
      if (arm) begin
        feat_ready <= 1'b1;
        wr_cnt     <= '0;
      end else if (take) begin
        wr_cnt <= wr_cnt + 1'b1;
        // last beat closes the port
        if (wr_cnt == beat_idx_t'(`FEATURE_BEATS - 1)) begin
          feat_ready <= 1'b0;
          full       <= 1'b1;
        end
      end
      if (clear) begin
        full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      beats[wr_cnt] <= feat_data;
    end
  end

  assign rd_data = (rd_idx < beat_idx_t'(`FEATURE_BEATS)) ? beats[rd_idx] : '0;

endmodule

//--- src/anchor_adder.sv
`timescale 1ns/10ps
`include "octree_config.svh"

module anchor_adder import octree_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  pos_t       pos,
  output level_t     level,
  input  word_addr_t word_addr,
  input  lane_t      lane,
  input  offset_t    offset,
  output beat_idx_t  feat_idx,
  input  data_t      feat_data,
  input  logic       feat_full,
  output logic       feat_clear,
  output logic       finish,
  output logic       sram_cen,
  output logic       sram_wen,
  output word_addr_t sram_addr,
  output data_t      sram_d,
  input  data_t      sram_q
);

  localparam int unsigned PRIMES [`TREE_LEVELS] =
    '{`PRIME_0, `PRIME_1, `PRIME_2, `PRIME_3, `PRIME_4};

  walk_e              state;
  level_t             level_q;
  logic               first_q;
  beat_idx_t          beat_q;
  level_t             anchor_level;
  logic [`LANE_W-1:0] old_lane;
  logic [5:0]         bit_idx;
  data_t              new_word;
  logic               climb;
  logic [31:0]        hash_acc;
  logic [`HASH_W-1:0] hash;
  word_addr_t         feat_addr;

  assign level        = level_q;
  assign anchor_level = pos[`LOG_CHILDREN*`TREE_LEVELS +: 3];

  // self bit on the first visit, child bit on every ancestor
  assign bit_idx  = {lane, offset, first_q};
  assign old_lane = sram_q[lane*`LANE_W +: `LANE_W];
  assign new_word = sram_q | (data_t'(1) << bit_idx);
  // an empty group needs its parent marked too
  assign climb    = (old_lane == '0) && (level_q != '0);

  // xor of (offset+1)*prime over levels 0..L
  always_comb begin
    hash_acc = '0;
    for (int i = 0; i < `TREE_LEVELS; i++) begin
      if (i <= int'(anchor_level)) begin
        hash_acc = hash_acc ^
          ((32'(pos[`LOG_CHILDREN*(`TREE_LEVELS-1-i) +: `LOG_CHILDREN]) + 32'd1) * PRIMES[i]);
      end
    end
  end

  assign hash      = hash_acc[`HASH_W-1:0];
  assign feat_addr = word_addr_t'(`FEATURE_BASE) + word_addr_t'(hash) + word_addr_t'(beat_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= W_IDLE;
      level_q <= '0;
      first_q <= 1'b0;
      beat_q  <= '0;
    end else begin
      case (state)
        W_IDLE: begin
          if (start) begin
            level_q <= anchor_level;
            first_q <= 1'b1;
            state   <= W_READ;
          end
        end
        W_READ: begin
          state <= W_WRITE;
        end
        W_WRITE: begin
          if (climb) begin
            level_q <= level_q - 1'b1;
            first_q <= 1'b0;
            state   <= W_READ;
          end else begin
            beat_q <= '0;
            state  <= W_FEATURE;
          end
        end
        W_FEATURE: begin
          // stalls here until the buffer holds all beats
          if (feat_full) begin
            beat_q <= beat_q + 1'b1;
            if (beat_q == beat_idx_t'(`FEATURE_BEATS - 1)) begin
              state <= W_DONE;
            end
          end
        end
        W_DONE: begin
          state <= W_IDLE;
        end
        default: begin
          state <= W_IDLE;
        end
      endcase
    end
  end

  always_comb begin
    sram_cen  = 1'b1;
    sram_wen  = 1'b1;
    sram_addr = word_addr;
    sram_d    = new_word;
    case (state)
      W_READ: begin
        sram_cen = 1'b0;
      end
      W_WRITE: begin
        sram_cen = 1'b0;
        sram_wen = 1'b0;
      end
      W_FEATURE: begin
        sram_addr = feat_addr;
        sram_d    = feat_data;
        if (feat_full) begin
          sram_cen = 1'b0;
          sram_wen = 1'b0;
        end
      end
      default: begin
        sram_cen = 1'b1;
      end
    endcase
  end

  assign feat_idx   = beat_q;
  assign finish     = (state == W_DONE);
  assign feat_clear = finish;

endmodule

//--- src/anchor_deleter.sv
`timescale 1ns/10ps
`include "octree_config.svh"

module anchor_deleter import octree_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  pos_t       pos,
  output level_t     level,
  input  word_addr_t word_addr,
  input  lane_t      lane,
  input  offset_t    offset,
  output logic       finish,
  output logic       sram_cen,
  output logic       sram_wen,
  output word_addr_t sram_addr,
  output data_t      sram_d,
  input  data_t      sram_q
);

  walk_e              state;
  level_t             level_q;
  logic               first_q;
  logic [5:0]         bit_idx;
  data_t              new_word;
  logic [`LANE_W-1:0] new_lane;
  logic               climb;

  assign level = level_q;

  // self bit first, then the child bit of each ancestor
  assign bit_idx  = {lane, offset, first_q};
  assign new_word = sram_q & ~(data_t'(1) << bit_idx);
  assign new_lane = new_word[lane*`LANE_W +: `LANE_W];
  // group left empty, so the parent loses this child
  assign climb    = (new_lane == '0) && (level_q != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= W_IDLE;
      level_q <= '0;
      first_q <= 1'b0;
    end else begin
      case (state)
        W_IDLE: begin
          if (start) begin
            level_q <= pos[`LOG_CHILDREN*`TREE_LEVELS +: 3];
            first_q <= 1'b1;
            state   <= W_READ;
          end
        end
        W_READ: begin
          state <= W_WRITE;
        end
        W_WRITE: begin
          if (climb) begin
            level_q <= level_q - 1'b1;
            first_q <= 1'b0;
            state   <= W_READ;
          end else begin
            state <= W_DONE;
          end
        end
        default: begin
          state <= W_IDLE;
        end
      endcase
    end
  end

  // read address and write address are the same group
  assign sram_addr = word_addr;
  assign sram_d    = new_word;
  assign sram_cen  = !((state == W_READ) || (state == W_WRITE));
  assign sram_wen  = (state != W_WRITE);
  assign finish    = (state == W_DONE);

endmodule

//--- src/octree_updater.sv
`timescale 1ns/10ps

module octree_updater import octree_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  op_e        cmd_op,
  input  pos_t       cmd_pos,
  input  logic       feat_valid,
  output logic       feat_ready,
  input  data_t      feat_data,
  output logic       done,
  output logic       sram_cen,
  output logic       sram_wen,
  output word_addr_t sram_addr,
  output data_t      sram_d,
  input  data_t      sram_q
);

  logic       busy_q;
  logic       start_q;
  op_e        op_q;
  pos_t       pos_q;
  logic       accept;

  level_t     add_level, del_level;
  word_addr_t add_waddr, del_waddr;
  lane_t      add_lane, del_lane;
  offset_t    add_offset, del_offset;
  logic       add_finish, del_finish;
  logic       add_cen, add_wen, del_cen, del_wen;
  word_addr_t add_addr, del_addr;
  data_t      add_d, del_d;

  beat_idx_t  feat_idx;
  data_t      feat_rd_data;
  logic       feat_full, feat_clear;

  assign cmd_ready = !busy_q;
  assign accept    = cmd_valid && cmd_ready;

  // idle / adding / deleting is busy_q plus op_q
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      op_q    <= OP_ADD;
      done    <= 1'b0;
    end else begin
      start_q <= accept;
      done    <= add_finish || del_finish;
      if (accept) begin
        busy_q <= 1'b1;
        op_q   <= cmd_op;
      end else if (done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pos_q <= cmd_pos;
    end
  end

  // port is parked when no engine owns it
  always_comb begin
    sram_cen  = 1'b1;
    sram_wen  = 1'b1;
    sram_addr = '0;
    sram_d    = '0;
    if (busy_q && op_q == OP_ADD) begin
      sram_cen  = add_cen;
      sram_wen  = add_wen;
      sram_addr = add_addr;
      sram_d    = add_d;
    end else if (busy_q && op_q == OP_DEL) begin
      sram_cen  = del_cen;
      sram_wen  = del_wen;
      sram_addr = del_addr;
      sram_d    = del_d;
    end
  end

  node_addr_calc i_add_calc (
    .pos(pos_q), .level(add_level), .word_addr(add_waddr), .lane(add_lane), .offset(add_offset)
  );

  node_addr_calc i_del_calc (
    .pos(pos_q), .level(del_level), .word_addr(del_waddr), .lane(del_lane), .offset(del_offset)
  );

  // armed on add acceptance so beats can stream in during the walk
  feature_buffer i_feature_buffer (
    .clk(clk), .rst_n(rst_n), .arm(accept && cmd_op == OP_ADD),
    .feat_valid(feat_valid), .feat_ready(feat_ready), .feat_data(feat_data),
    .rd_idx(feat_idx), .rd_data(feat_rd_data), .full(feat_full), .clear(feat_clear)
  );

  anchor_adder i_adder (
    .clk(clk), .rst_n(rst_n), .start(start_q && op_q == OP_ADD), .pos(pos_q),
    .level(add_level), .word_addr(add_waddr), .lane(add_lane), .offset(add_offset),
    .feat_idx(feat_idx), .feat_data(feat_rd_data), .feat_full(feat_full),
    .feat_clear(feat_clear), .finish(add_finish),
    .sram_cen(add_cen), .sram_wen(add_wen), .sram_addr(add_addr), .sram_d(add_d),
    .sram_q(sram_q)
  );

  anchor_deleter i_deleter (
    .clk(clk), .rst_n(rst_n), .start(start_q && op_q == OP_DEL), .pos(pos_q),
    .level(del_level), .word_addr(del_waddr), .lane(del_lane), .offset(del_offset),
    .finish(del_finish),
    .sram_cen(del_cen), .sram_wen(del_wen), .sram_addr(del_addr), .sram_d(del_d),
    .sram_q(sram_q)
  );

endmodule

//--- tests/octree_updater_checker.sv
`timescale 1ns/10ps
`include "octree_config.svh"

module octree_updater_checker import octree_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       cmd_ready,
  input logic       feat_ready,
  input logic       done,
  input logic       sram_cen,
  input logic       sram_wen,
  input word_addr_t sram_addr
);

  int reset_fails = 0;
  int idle_cen_fails = 0;
  int done_fails = 0;
  int region_fails = 0;
  int idle_feat_fails = 0;
  int fail_cnt;

  assign fail_cnt = reset_fails + idle_cen_fails + done_fails + region_fails + idle_feat_fails;

  reset_idle: assert property (@(posedge clk)
    (!rst_n || $rose(rst_n)) |-> (sram_cen && !done && !feat_ready))
    else begin
      $error("control outputs active in or right after reset");
      reset_fails++;
    end

  idle_sram: assert property (@(posedge clk) disable iff (!rst_n) cmd_ready |-> sram_cen)
    else begin
      $error("sram enabled while the updater is idle");
      idle_cen_fails++;
    end

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> (!done && cmd_ready))
    else begin
      $error("done longer than one cycle or not followed by cmd_ready");
      done_fails++;
    end

  // a write that follows no read is a feature beat
  feature_region: assert property (@(posedge clk) disable iff (!rst_n)
    (!sram_cen && !sram_wen && !$past(!sram_cen && sram_wen))
      |-> (sram_addr >= word_addr_t'(`FEATURE_BASE)) &&
          (sram_addr < word_addr_t'(`FEATURE_BASE + (1 << `HASH_W) + `FEATURE_BEATS - 1)))
    else begin
      $error("feature write outside the feature region");
      region_fails++;
    end

  idle_feat: assert property (@(posedge clk) disable iff (!rst_n) cmd_ready |-> !feat_ready)
    else begin
      $error("feature port open while the updater is idle");
      idle_feat_fails++;
    end

endmodule

bind octree_updater octree_updater_checker i_checker (
  .clk(clk), .rst_n(rst_n), .cmd_ready(cmd_ready), .feat_ready(feat_ready), .done(done),
  .sram_cen(sram_cen), .sram_wen(sram_wen), .sram_addr(sram_addr)
);

//--- tests/tb_octree_updater.sv
`timescale 1ns/10ps
`include "octree_config.svh"

module tb_octree_updater import octree_pkg::*; ();

  localparam int NUM_CMDS   = 31;
  localparam int MAX_CYCLES = NUM_CMDS * 60 + 200;
  // 4681 groups at four per word
  localparam int TREE_WORDS = 1171;
  localparam int MEM_WORDS  = 1 << `ADDR_W;

  logic       clk, rst_n;
  logic       cmd_valid, cmd_ready;
  op_e        cmd_op;
  pos_t       cmd_pos;
  logic       feat_valid, feat_ready;
  data_t      feat_data;
  logic       done;
  logic       sram_cen, sram_wen;
  word_addr_t sram_addr;
  data_t      sram_d, sram_q;

  data_t mem    [MEM_WORDS];
  data_t shadow [MEM_WORDS];
  op_e   op_list [$];
  pos_t  pos_list [$];
  data_t beat_list [$];
  int    seed = 74;
  int    cycle_cnt = 0;
  int    done_cnt = 0;
  int    accept_cnt = 0;
  int    err_cnt, test_err, test_cnt, bad_tests;
  logic  gaps_on;
  pos_t  pool [6];

  octree_updater i_dut (
    .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .cmd_op(cmd_op), .cmd_pos(cmd_pos), .feat_valid(feat_valid), .feat_ready(feat_ready),
    .feat_data(feat_data), .done(done), .sram_cen(sram_cen), .sram_wen(sram_wen),
    .sram_addr(sram_addr), .sram_d(sram_d), .sram_q(sram_q)
  );

  always #5 clk = ~clk;

  // single-port sram with read data one cycle later
  initial begin
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] <= '0;
    end
  end

  always @(posedge clk) begin
    if (!sram_cen && sram_wen) begin
      sram_q <= mem[sram_addr];
    end
    if (!sram_cen && !sram_wen) begin
      mem[sram_addr] <= sram_d;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (done) begin
      done_cnt <= done_cnt + 1;
    end
    if (cmd_valid && cmd_ready) begin
      accept_cnt <= accept_cnt + 1;
    end
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles, %0d commands done", cycle_cnt, done_cnt);
      $display("test failed");
      $finish;
    end
  end

  function automatic pos_t make_pos(int lvl, int o0, int o1, int o2, int o3, int o4);
    return {3'(lvl), 3'(o0), 3'(o1), 3'(o2), 3'(o3), 3'(o4)};
  endfunction

  function automatic int offset_of(pos_t p, int i);
    return int'(p[14 - 3 * i -: 3]);
  endfunction

  // level base plus the ancestor offsets read as base-8 digits
  function automatic int group_of(pos_t p, int lvl);
    int base [5] = '{0, 1, 9, 73, 585};
    int g;
    g = 0;
    for (int i = 0; i < lvl; i++) begin
      g = g * 8 + offset_of(p, i);
    end
    return base[lvl] + g;
  endfunction

  function automatic int hash_of(pos_t p);
    int unsigned primes [5] = '{`PRIME_0, `PRIME_1, `PRIME_2, `PRIME_3, `PRIME_4};
    int unsigned h;
    h = 0;
    for (int i = 0; i <= int'(p[17:15]) && i < 5; i++) begin
      h = h ^ (unsigned'(offset_of(p, i) + 1) * primes[i]);
    end
    return int'(h % (1 << `HASH_W));
  endfunction

  // add stops at a group that already had bits, delete at one that keeps some
  function automatic void apply_cmd(op_e op, pos_t p, int first_beat);
    int          lvl, g, b;
    logic        first;
    logic [15:0] old_lane, new_lane;
    lvl   = int'(p[17:15]);
    first = 1'b1;
    do begin
      g        = group_of(p, lvl);
      b        = 16 * (g % 4) + 2 * offset_of(p, lvl) + int'(first);
      old_lane = shadow[g / 4][16 * (g % 4) +: 16];
      shadow[g / 4][b] = (op == OP_ADD);
      new_lane = shadow[g / 4][16 * (g % 4) +: 16];
      first    = 1'b0;
      lvl--;
    end while ((((op == OP_ADD) ? old_lane : new_lane) == '0) && lvl >= 0);
    if (op == OP_ADD) begin
      for (int k = 0; k < `FEATURE_BEATS; k++) begin
        shadow[`FEATURE_BASE + hash_of(p) + k] = beat_list[first_beat + k];
      end
    end
  endfunction

  function automatic void check_value(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      test_err++;
    end
  endfunction

  function automatic void check_memory();
    int bad;
    bad = 0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      assert (mem[a] === shadow[a]) else begin
        if (bad == 0) begin
          $display("Fail mem[%h]: got %h, expected %h", a[12:0], mem[a], shadow[a]);
        end
        bad++;
      end
    end
    if (bad > 0) begin
      test_err++;
    end
  endfunction

  function automatic int tree_ones();
    int n;
    n = 0;
    for (int a = 0; a < TREE_WORDS; a++) begin
      n += $countones(mem[a]);
    end
    return n;
  endfunction

  function automatic void queue_cmd(op_e op, pos_t p);
    op_list.push_back(op);
    pos_list.push_back(p);
    if (op == OP_ADD) begin
      for (int k = 0; k < `FEATURE_BEATS; k++) begin
        beat_list.push_back({$random(seed), $random(seed)});
      end
    end
  endfunction

  // valid stays up while the DUT is busy
  task automatic send_cmds();
    foreach (op_list[i]) begin
      cmd_valid = 1'b1;
      cmd_op    = op_list[i];
      cmd_pos   = pos_list[i];
      while (!cmd_ready) @(negedge clk);
      @(negedge clk);
    end
    cmd_valid = 1'b0;
  endtask

  task automatic send_beats();
    int gap;
    foreach (beat_list[k]) begin
      gap = gaps_on ? ($random(seed) & 3) : 0;
      repeat (gap) @(negedge clk);
      feat_valid = 1'b1;
      feat_data  = beat_list[k];
      while (!feat_ready) @(negedge clk);
      @(negedge clk);
      feat_valid = 1'b0;
    end
  endtask

  task automatic run_batch();
    int target, nb;
    target = done_cnt + op_list.size();
    fork
      send_cmds();
      send_beats();
    join
    while (done_cnt < target) @(negedge clk);
    check_value("done pulses", 64'(done_cnt), 64'(accept_cnt));
    nb = 0;
    foreach (op_list[i]) begin
      apply_cmd(op_list[i], pos_list[i], nb);
      if (op_list[i] == OP_ADD) begin
        nb += `FEATURE_BEATS;
      end
    end
    check_memory();
    op_list.delete();
    pos_list.delete();
    beat_list.delete();
  endtask

  function automatic void end_test(string name);
    $display("%s: %0d errors", name, test_err);
    err_cnt += test_err;
    bad_tests += (test_err > 0) ? 1 : 0;
    test_cnt++;
    test_err = 0;
  endfunction

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    cmd_valid  = 1'b0;
    cmd_op     = OP_ADD;
    cmd_pos    = '0;
    feat_valid = 1'b0;
    feat_data  = '0;
    gaps_on    = 1'b0;
    err_cnt    = 0;
    test_err   = 0;
    test_cnt   = 0;
    bad_tests  = 0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      shadow[a] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("sram_cen", 64'(sram_cen), 64'h1);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("cmd_ready", 64'(cmd_ready), 64'h1);
    check_value("feat_ready", 64'(feat_ready), 64'h0);
    check_value("done", 64'(done), 64'h0);
    check_value("sram_cen", 64'(sram_cen), 64'h1);
    end_test("reset");

    // offset 3 self bit is bit 7 of word 0
    queue_cmd(OP_ADD, make_pos(0, 3, 0, 0, 0, 0));
    run_batch();
    check_value("mem[0000]", mem[0], 64'h80);
    queue_cmd(OP_DEL, make_pos(0, 3, 0, 0, 0, 0));
    run_batch();
    check_value("mem[0000]", mem[0], 64'h0);
    end_test("level-0 add");

    // one self bit plus three ancestor child bits
    queue_cmd(OP_ADD, make_pos(3, 2, 5, 1, 6, 0));
    run_batch();
    check_value("tree bit count", 64'(tree_ones()), 64'd4);
    queue_cmd(OP_ADD, make_pos(3, 2, 5, 1, 4, 0));
    run_batch();
    check_value("tree bit count", 64'(tree_ones()), 64'd5);
    end_test("level-3 add");

    queue_cmd(OP_DEL, make_pos(3, 2, 5, 1, 6, 0));
    run_batch();
    check_value("tree bit count", 64'(tree_ones()), 64'd4);
    queue_cmd(OP_DEL, make_pos(3, 2, 5, 1, 4, 0));
    run_batch();
    check_value("tree bit count", 64'(tree_ones()), 64'd0);
    end_test("delete");

    gaps_on = 1'b1;
    queue_cmd(OP_ADD, make_pos(4, 1, 2, 3, 4, 5));
    queue_cmd(OP_ADD, make_pos(2, 7, 7, 0, 0, 0));
    queue_cmd(OP_DEL, make_pos(4, 1, 2, 3, 4, 5));
    queue_cmd(OP_ADD, make_pos(1, 0, 6, 0, 0, 0));
    queue_cmd(OP_ADD, make_pos(4, 1, 2, 3, 4, 6));
    run_batch();
    end_test("back-pressure");

    // small offsets so the pool shares ancestors
    for (int i = 0; i < 6; i++) begin
      pool[i] = make_pos(($random(seed) & 32'h7fff_ffff) % 5, $random(seed) & 1,
                         $random(seed) & 1, $random(seed) & 1, $random(seed) & 1,
                         $random(seed) & 1);
    end
    for (int i = 0; i < 20; i++) begin
      queue_cmd(($random(seed) & 1) ? OP_DEL : OP_ADD,
                pool[($random(seed) & 32'h7fff_ffff) % 6]);
    end
    run_batch();
    end_test("random sequence");

    $display("%0d tests, %0d with errors, %0d check errors, %0d assertion failures",
             test_cnt, bad_tests, err_cnt, i_dut.i_checker.fail_cnt);
    if (err_cnt == 0 && i_dut.i_checker.fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+src
src/octree_pkg.sv
src/node_addr_calc.sv
src/feature_buffer.sv
src/anchor_adder.sv
src/anchor_deleter.sv
src/octree_updater.sv
tests/octree_updater_checker.sv
tests/tb_octree_updater.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_octree_updater
RTL_TOP    ?= octree_updater
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
SOURCES    := $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
